/* files.f */
verilog/lsu_bus_pkg.sv
verilog/lsu_csr_pkg.sv
verilog/lsu_slice.sv
verilog/lsu_align.sv
verilog/lsu_csr.sv
verilog/lsu_sram.sv
verilog/lsu_top.sv
testbench/lsu_tb.sv

/* run_sim.sh */
#!/bin/sh
# build the load/store testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing -j 0 --top-module lsu_tb -f files.f -o lsu_sim
./obj_dir/lsu_sim | tee sim.log

# the log decides the outcome
if grep -q "Simulation passed" sim.log; then
  echo "run_sim: PASS"
  exit 0
fi
echo "run_sim: FAIL"
exit 1

/* testbench/lsu_tb.sv */
////////////////////////////////////////////////////////////////////////////
// load/store path testbench
// directed tests against a byte model of the memory, lane rule applied
// on every request; responses checked in order by a collector
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module lsu_tb;

  import lsu_bus_pkg::*;
  import lsu_csr_pkg::*;

  // requests per test, drives the watchdog budget
  localparam int n_fill    = 256;
  localparam int n_le      = 16;
  localparam int n_endian  = 16;
  localparam int n_wrap    = 10;
  localparam int n_trap    = 12;
  localparam int n_cnt     = 10;
  localparam int n_burst   = 64;
  localparam int n_total   = n_fill + n_le + n_endian + n_wrap + n_trap + n_cnt + n_burst;
  localparam int wd_cycles = 16 + 40 * n_total;

  logic              clk;
  logic              rst;
  logic              req_vld;
  logic              req_wen;
  logic              req_ndn;
  logic [siz_w-1:0]  req_siz;
  logic [bus_aw-1:0] req_adr;
  logic [bus_dw-1:0] req_wdt;
  logic              req_rdy;
  logic              mal;
  logic              rsp_vld;
  logic [bus_dw-1:0] rsp_rdt;
  logic              rsp_sts;
  logic              rsp_rdy;
  logic              csr_req;
  logic              csr_wen;
  logic [csr_aw-1:0] csr_adr;
  logic [csr_dw-1:0] csr_wdt;
  logic              csr_ack;
  logic [csr_dw-1:0] csr_rdt;

  // byte model, index is {word, lane}
  logic [7:0]  model_mem [mem_words*bus_bw];
  logic [31:0] exp_rdt [$];
  logic        exp_sts [$];
  logic        trap_model;
  int          acc_model;
  int          mal_model;
  int          seed = 32'h2eea;
  int          chk_cnt;
  int          err_cnt;
  int          chk_mark;
  int          err_mark;
  // random ready pattern for bursts
  bit [127:0]  rdy_pat;
  logic [6:0]  rdy_idx;
  logic        rdy_rand;

  lsu_top dut (.*);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

////////////////////////////////////////////////////////////////////////////
// checks and bookkeeping
////////////////////////////////////////////////////////////////////////////

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    chk_cnt++;
    if (got !== exp) begin
      $display("Fail %s: got %h, expected %h", name, got, exp);
      err_cnt++;
    end
  endtask

  task automatic test_start();
    chk_mark = chk_cnt;
    err_mark = err_cnt;
  endtask

  task automatic test_done(input string name);
    $display("%s done: %0d checks, %0d errors", name, chk_cnt - chk_mark, err_cnt - err_mark);
  endtask

  // clear the low address bits the size needs
  function automatic logic [9:0] align_adr(input logic [9:0] adr, input logic [1:0] siz);
    case (siz)
      2'd0:    return adr;
      2'd1:    return {adr[9:1], 1'b0};
      default: return {adr[9:2], 2'b00};
    endcase
  endfunction

  // depends on every word address bit
  function automatic logic [31:0] fill_word(input logic [7:0] w);
    return {w, ~w, w ^ 8'h5a, w * 8'd3};
  endfunction

////////////////////////////////////////////////////////////////////////////
// bus tasks, all entered and left 1 ns after a rising edge
////////////////////////////////////////////////////////////////////////////

  // predict the response, update the model, then drive until accepted
  task automatic send_req(input logic wen, input logic ndn, input logic [1:0] siz,
                          input logic [9:0] adr, input logic [31:0] wdt);
    int          n;
    logic [1:0]  off;
    logic [7:0]  wrd;
    logic [1:0]  lane;
    logic        m;
    logic        err;
    logic [31:0] rdt;
    off = adr[1:0];
    wrd = adr[9:2];
    n   = 1 << siz;
    m   = (siz == 2'd3) || ((int'(off) % n) != 0);
    err = m && (trap_model || (siz == 2'd3));
    rdt = '0;
    if (!err) begin
      for (int k = 0; k < n; k++) begin
        // lane rule, wraps inside the word
        lane = ndn ? 2'(int'(off) + n - 1 - k) : 2'(int'(off) + k);
        if (wen) model_mem[{wrd, lane}] = wdt[8*k +: 8];
        else rdt[8*k +: 8] = model_mem[{wrd, lane}];
      end
    end
    exp_rdt.push_back(rdt);
    exp_sts.push_back(err);
    acc_model++;
    if (m) mal_model++;
    req_vld = 1'b1;
    req_wen = wen;
    req_ndn = ndn;
    req_siz = siz;
    req_adr = adr;
    req_wdt = wdt;
    #1;
    check_val("mal", 32'(mal), 32'(m));
    while (!req_rdy) begin
      @(posedge clk);
      #1;
    end
    @(posedge clk);
    #1;
    req_vld = 1'b0;
  endtask

  // responses drain through the collector
  task automatic wait_rsp();
    while (exp_rdt.size() != 0) begin
      @(posedge clk);
      #1;
    end
  endtask

  // four-phase register access
  task automatic csr_access(input logic wen, input logic [1:0] adr, input logic [31:0] wdt,
                            output logic [31:0] rdt);
    csr_req = 1'b1;
    csr_wen = wen;
    csr_adr = adr;
    csr_wdt = wdt;
    @(posedge clk);
    #1;
    while (!csr_ack) begin
      @(posedge clk);
      #1;
    end
    rdt = csr_rdt;
    csr_req = 1'b0;
    while (csr_ack) begin
      @(posedge clk);
      #1;
    end
    csr_wen = 1'b0;
  endtask

  task automatic csr_write(input logic [1:0] adr, input logic [31:0] wdt);
    logic [31:0] dummy;
    csr_access(1'b1, adr, wdt, dummy);
  endtask

  task automatic csr_read(input logic [1:0] adr, output logic [31:0] rdt);
    csr_access(1'b0, adr, '0, rdt);
  endtask

  task automatic set_trap(input logic v);
    logic [31:0] r;
    csr_write(csr_ctrl, {31'd0, v});
    trap_model = v;
    csr_read(csr_ctrl, r);
    check_val("csr_ctrl", r, {31'd0, v});
  endtask

  // responses in order against the prediction queue
  always @(negedge clk) begin
    logic [31:0] e_rdt;
    logic        e_sts;
    if (!rst && rsp_vld && rsp_rdy) begin
      if (exp_rdt.size() == 0) begin
        $display("response arrived with no request outstanding");
        err_cnt++;
      end else begin
        e_rdt = exp_rdt.pop_front();
        e_sts = exp_sts.pop_front();
        check_val("rsp_rdt", rsp_rdt, e_rdt);
        check_val("rsp_sts", 32'(rsp_sts), 32'(e_sts));
      end
    end
  end

  // random back-pressure
  always @(posedge clk) begin
    #1;
    if (rdy_rand) begin
      rsp_rdy = rdy_pat[rdy_idx];
      rdy_idx = rdy_idx + 7'd1;
    end
  end

////////////////////////////////////////////////////////////////////////////
// tests
////////////////////////////////////////////////////////////////////////////

  task automatic test_reset();
    logic [31:0] r;
    test_start();
    csr_read(csr_ctrl, r);
    check_val("csr_ctrl", r, 32'd0);
    csr_read(csr_mal_cnt, r);
    check_val("csr_mal_cnt", r, 32'd0);
    csr_read(csr_acc_cnt, r);
    check_val("csr_acc_cnt", r, 32'd0);
    test_done("reset");
  endtask

  // every word known before any read
  task automatic test_fill();
    test_start();
    for (int i = 0; i < n_fill; i++) begin
      send_req(1'b1, 1'b0, 2'd2, {8'(i), 2'b00}, fill_word(8'(i)));
    end
    wait_rsp();
    test_done("fill");
  endtask

  task automatic test_le_aligned();
    logic [1:0]  siz;
    logic [9:0]  adr;
    test_start();
    for (int i = 0; i < n_le / 2; i++) begin
      siz = 2'(i % 3);
      adr = align_adr(10'($random(seed)), siz);
      send_req(1'b1, 1'b0, siz, adr, $random(seed));
      send_req(1'b0, 1'b0, siz, adr, '0);
    end
    wait_rsp();
    test_done("little-endian aligned");
  endtask

  // writes in one order, reads in the other
  task automatic test_endian();
    logic [1:0] siz;
    logic [9:0] adr;
    test_start();
    for (int i = 0; i < n_endian / 4; i++) begin
      siz = i[0] ? 2'd2 : 2'd1;
      adr = align_adr(10'($random(seed)), siz);
      send_req(1'b1, 1'b1, siz, adr, $random(seed));
      send_req(1'b0, 1'b0, siz, adr, '0);
      send_req(1'b1, 1'b0, siz, adr, $random(seed));
      send_req(1'b0, 1'b1, siz, adr, '0);
    end
    wait_rsp();
    test_done("endianness");
  endtask

  task automatic test_wrap();
    logic [1:0] sizs [5] = '{2'd1, 2'd1, 2'd2, 2'd2, 2'd2};
    logic [1:0] offs [5] = '{2'd1, 2'd3, 2'd1, 2'd2, 2'd3};
    logic [9:0] adr;
    logic       ndn;
    test_start();
    set_trap(1'b0);
    for (int i = 0; i < n_wrap / 2; i++) begin
      adr = {8'($random(seed)), offs[i]};
      ndn = 1'($random(seed));
      send_req(1'b1, ndn, sizs[i], adr, $random(seed));
      send_req(1'b0, ~ndn, sizs[i], adr, '0);
    end
    wait_rsp();
    test_done("misaligned wrap");
  endtask

  // trapped accesses leave memory alone
  task automatic test_trap();
    logic [9:0] base;
    test_start();
    set_trap(1'b1);
    for (int i = 0; i < n_trap / 6; i++) begin
      base = {8'($random(seed)), 2'b00};
      send_req(1'b1, 1'b0, 2'd2, base | 10'd1, $random(seed));
      send_req(1'b1, 1'b1, 2'd1, base | 10'd3, $random(seed));
      send_req(1'b1, 1'b0, 2'd3, base, $random(seed));
      send_req(1'b0, 1'b0, 2'd2, base | 10'd2, '0);
      send_req(1'b0, 1'b0, 2'd3, base, '0);
      send_req(1'b0, 1'b0, 2'd2, base, '0);
    end
    wait_rsp();
    set_trap(1'b0);
    test_done("trap");
  endtask

  task automatic test_counters();
    logic [31:0] r;
    logic [1:0]  siz;
    test_start();
    csr_write(csr_mal_cnt, '0);
    csr_write(csr_acc_cnt, '0);
    acc_model = 0;
    mal_model = 0;
    for (int i = 0; i < n_cnt; i++) begin
      siz = 2'(i % 3);
      send_req(1'($random(seed)), 1'($random(seed)), siz, 10'($random(seed)),
               $random(seed));
    end
    wait_rsp();
    csr_read(csr_mal_cnt, r);
    check_val("csr_mal_cnt", r, 32'(mal_model));
    csr_read(csr_acc_cnt, r);
    check_val("csr_acc_cnt", r, 32'(acc_model));
    // each clear touches only its own counter
    csr_write(csr_mal_cnt, 32'hffff_ffff);
    csr_read(csr_mal_cnt, r);
    check_val("csr_mal_cnt", r, 32'd0);
    csr_read(csr_acc_cnt, r);
    check_val("csr_acc_cnt", r, 32'(acc_model));
    csr_write(csr_acc_cnt, 32'd1);
    csr_read(csr_acc_cnt, r);
    check_val("csr_acc_cnt", r, 32'd0);
    test_done("counters");
  endtask

  task automatic test_burst();
    int         r;
    logic [1:0] siz;
    test_start();
    for (int j = 0; j < 4; j++) rdy_pat[32*j +: 32] = $random(seed);
    rdy_idx  = '0;
    rdy_rand = 1'b1;
    for (int i = 0; i < n_burst; i++) begin
      r   = $random(seed);
      siz = (r[1:0] == 2'd3) ? 2'd2 : r[1:0];
      send_req(r[2], r[3], siz, 10'($random(seed)), $random(seed));
    end
    wait_rsp();
    rdy_rand = 1'b0;
    rsp_rdy  = 1'b1;
    test_done("burst");
  endtask

////////////////////////////////////////////////////////////////////////////
// main sequence and watchdog
////////////////////////////////////////////////////////////////////////////

  initial begin
    rst        = 1'b1;
    req_vld    = 1'b0;
    req_wen    = 1'b0;
    req_ndn    = 1'b0;
    req_siz    = '0;
    req_adr    = '0;
    req_wdt    = '0;
    rsp_rdy    = 1'b1;
    csr_req    = 1'b0;
    csr_wen    = 1'b0;
    csr_adr    = '0;
    csr_wdt    = '0;
    trap_model = 1'b0;
    acc_model  = 0;
    mal_model  = 0;
    chk_cnt    = 0;
    err_cnt    = 0;
    rdy_pat    = '0;
    rdy_idx    = '0;
    rdy_rand   = 1'b0;
    repeat (16) @(posedge clk);
    #1;
    // outputs quiet while in reset
    check_val("req_rdy", 32'(req_rdy), 32'd0);
    check_val("rsp_vld", 32'(rsp_vld), 32'd0);
    check_val("csr_ack", 32'(csr_ack), 32'd0);
    rst = 1'b0;
    test_reset();
    test_fill();
    test_le_aligned();
    test_endian();
    test_wrap();
    test_trap();
    test_counters();
    test_burst();
    $display("tests 8, checks %0d, errors %0d", chk_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  initial begin
    repeat (wd_cycles) @(posedge clk);
    $display("run timed out after %0d cycles with tests still running", wd_cycles);
    $display("Simulation failed");
    $finish;
  end

endmodule

/* verilog/lsu_align.sv */
////////////////////////////////////////////////////////////////////////////
// load/store aligner
// converts reference form requests to memory form: word address, byte
// enables and rotated write data; keeps lane info per outstanding
// request and rotates read data back to the low bytes
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module lsu_align (
  input  logic                           clk,
  input  logic                           rst,
  // request, reference form
  input  logic                           req_vld,
  input  lsu_bus_pkg::lsu_req_t          req_data,
  output logic                           req_rdy,
  // request, memory form
  output logic                           mem_vld,
  output logic                           mem_wen,
  output logic [lsu_bus_pkg::mem_aw-1:0] mem_adr,
  output logic [lsu_bus_pkg::bus_bw-1:0] mem_ben,
  output logic [lsu_bus_pkg::bus_dw-1:0] mem_wdt,
  input  logic                           mem_rdy,
  // response, memory form
  input  logic                           mem_rsp_vld,
  input  logic [lsu_bus_pkg::bus_dw-1:0] mem_rdt,
  output logic                           mem_rsp_rdy,
  // response, reference form
  output logic                           rsp_vld,
  output lsu_bus_pkg::lsu_rsp_t          rsp_data,
  input  logic                           rsp_rdy,
  // register block
  input  logic                           trap,
  output logic                           acc_evt,
  output logic                           mal_evt
);

  import lsu_bus_pkg::*;

////////////////////////////////////////////////////////////////////////////
// request side
////////////////////////////////////////////////////////////////////////////

  logic       req_acc;
  logic       req_mal;
  logic       req_err;
  // byte offset in word and byte count minus one
  logic [1:0] req_off;
  logic [1:0] req_nm1;

  // lane queue, wrap bit on top of the index
  logic [$clog2(lane_q_depth):0]   wr_ptr;
  logic [$clog2(lane_q_depth):0]   rd_ptr;
  logic [$clog2(lane_q_depth)-1:0] wr_idx;
  logic [$clog2(lane_q_depth)-1:0] rd_idx;
  logic                            q_full;
  logic [1:0]                      q_off [lane_q_depth];
  logic [1:0]                      q_nm1 [lane_q_depth];
  logic                            q_ndn [lane_q_depth];
  logic                            q_err [lane_q_depth];

  assign req_off = req_data.adr[1:0];
  assign req_mal = lsu_mal(req_data.siz, req_off);
  // 64-bit size is always trapped
  assign req_err = req_mal & (trap | (req_data.siz == siz_dbl));

  always_comb begin
    case (req_data.siz)
      siz_byte: req_nm1 = 2'd0;
      siz_half: req_nm1 = 2'd1;
      default:  req_nm1 = 2'd3;
    endcase
  end

  // hold off while the queue cannot take the lane info
  assign mem_vld = req_vld & ~q_full;
  assign req_rdy = mem_rdy & ~q_full;
  assign req_acc = req_vld & req_rdy;

  assign mem_wen = req_data.wen;
  assign mem_adr = req_data.adr[bus_aw-1:2];

  // memory lane i takes request byte k
  always_comb begin
    logic [1:0] lane;
    logic [1:0] k;
    for (int i = 0; i < bus_bw; i++) begin
      lane = 2'(i);
      if (req_data.ndn) k = req_off + req_nm1 - lane;
      else k = lane - req_off;
      // trapped access goes out with no lanes enabled
      mem_ben[i] = ~req_err & (k <= req_nm1);
      mem_wdt[8*i +: 8] = req_data.wdt[8*k +: 8];
    end
  end

  assign acc_evt = req_acc;
  assign mal_evt = req_acc & req_mal;

////////////////////////////////////////////////////////////////////////////
// lane queue
////////////////////////////////////////////////////////////////////////////

  logic rsp_acc;

  assign wr_idx  = wr_ptr[$clog2(lane_q_depth)-1:0];
  assign rd_idx  = rd_ptr[$clog2(lane_q_depth)-1:0];
  assign q_full  = (wr_ptr[$clog2(lane_q_depth)] != rd_ptr[$clog2(lane_q_depth)]) &&
                   (wr_idx == rd_idx);
  assign rsp_acc = mem_rsp_vld & rsp_rdy;

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (req_acc) wr_ptr <= wr_ptr + 1'b1;
      if (rsp_acc) rd_ptr <= rd_ptr + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (req_acc) begin
      q_off[wr_idx] <= req_off;
      q_nm1[wr_idx] <= req_nm1;
      q_ndn[wr_idx] <= req_data.ndn;
      q_err[wr_idx] <= req_err;
    end
  end

////////////////////////////////////////////////////////////////////////////
// response side
////////////////////////////////////////////////////////////////////////////

  // memory answers in order, head entry belongs to it
  assign rsp_vld     = mem_rsp_vld;
  assign mem_rsp_rdy = rsp_rdy;

  // response byte k comes from memory lane
  always_comb begin
    logic [1:0] pos;
    logic [1:0] lane;
    for (int k = 0; k < bus_bw; k++) begin
      pos = 2'(k);
      if (q_ndn[rd_idx]) lane = q_off[rd_idx] + q_nm1[rd_idx] - pos;
      else lane = q_off[rd_idx] + pos;
      // bytes past the size and trapped data read as zero
      if ((pos <= q_nm1[rd_idx]) && !q_err[rd_idx]) begin
        rsp_data.rdt[8*k +: 8] = mem_rdt[8*lane +: 8];
      end else begin
        rsp_data.rdt[8*k +: 8] = 8'h00;
      end
    end
    rsp_data.sts = q_err[rd_idx];
  end

endmodule

/* verilog/lsu_bus_pkg.sv */
////////////////////////////////////////////////////////////////////////////
// load/store bus definitions
// bus widths, size codes, memory geometry and the request and response
// payloads shared by the core side and the memory side of the path
////////////////////////////////////////////////////////////////////////////

package lsu_bus_pkg;

  // data bus and byte lanes
  localparam int unsigned bus_dw = 32;
  localparam int unsigned bus_bw = bus_dw / 8;
  // byte address
  localparam int unsigned bus_aw = 10;

  // size code, bytes accessed = 2**siz
  localparam int unsigned siz_w = 2;
  localparam logic [siz_w-1:0] siz_byte = 2'd0;
  localparam logic [siz_w-1:0] siz_half = 2'd1;
  localparam logic [siz_w-1:0] siz_word = 2'd2;
  // 64-bit access, not on this bus
  localparam logic [siz_w-1:0] siz_dbl  = 2'd3;

  // word memory, index is the byte address without the low 2 bits
  localparam int unsigned mem_aw    = bus_aw - 2;
  localparam int unsigned mem_words = 2 ** mem_aw;

  // outstanding requests in the aligner lane queue
  // must stay a power of two
  localparam int unsigned lane_q_depth = 4;

  // request in reference form, write data in the low bytes
  typedef struct packed {
    logic              wen;
    logic              ndn;
    logic [siz_w-1:0]  siz;
    logic [bus_aw-1:0] adr;
    logic [bus_dw-1:0] wdt;
  } lsu_req_t;

  // response, read data back in the low bytes
  typedef struct packed {
    logic [bus_dw-1:0] rdt;
    logic              sts;
  } lsu_rsp_t;

  // misalignment decode, same for reads and writes
  function automatic logic lsu_mal(input logic [siz_w-1:0] siz, input logic [1:0] off);
    case (siz)
      siz_byte: return 1'b0;
      siz_half: return off[0];
      siz_word: return |off;
      // no 64-bit access here
      default:  return 1'b1;
    endcase
  endfunction

endpackage

/* verilog/lsu_csr.sv */
////////////////////////////////////////////////////////////////////////////
// load/store register block
// trap control and saturating access counters behind a four-phase
// req/ack register port
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module lsu_csr (
  input  logic                           clk,
  input  logic                           rst,
  // register port
  input  logic                           csr_req,
  input  logic                           csr_wen,
  input  logic [lsu_csr_pkg::csr_aw-1:0] csr_adr,
  input  logic [lsu_csr_pkg::csr_dw-1:0] csr_wdt,
  output logic                           csr_ack,
  output logic [lsu_csr_pkg::csr_dw-1:0] csr_rdt,
  // aligner
  input  logic                           acc_evt,
  input  logic                           mal_evt,
  output logic                           trap
);

  import lsu_csr_pkg::*;

  logic [csr_dw-1:0] mal_cnt;
  logic [csr_dw-1:0] acc_cnt;
  // access happens once per req
  logic              csr_go;
  logic [csr_dw-1:0] rd_val;

  assign csr_go = csr_req & ~csr_ack;

  // read mux
  always_comb begin
    rd_val = '0;
    case (csr_adr)
      csr_ctrl:    rd_val[csr_ctrl_trap] = trap;
      csr_mal_cnt: rd_val = mal_cnt;
      csr_acc_cnt: rd_val = acc_cnt;
      default:     rd_val = '0;
    endcase
  end

////////////////////////////////////////////////////////////////////////////
// handshake and registers
////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      csr_ack <= 1'b0;
      trap    <= 1'b0;
      mal_cnt <= '0;
      acc_cnt <= '0;
    end else begin
      // ack follows req one cycle later, both edges
      csr_ack <= csr_req;
      // counters hold at all ones
      if (mal_evt && (mal_cnt != '1)) mal_cnt <= mal_cnt + 1'b1;
      if (acc_evt && (acc_cnt != '1)) acc_cnt <= acc_cnt + 1'b1;
      // register write, clear beats a count
      if (csr_go && csr_wen) begin
        case (csr_adr)
          csr_ctrl:    trap    <= csr_wdt[csr_ctrl_trap];
          csr_mal_cnt: mal_cnt <= '0;
          csr_acc_cnt: acc_cnt <= '0;
          default:     ;
        endcase
      end
    end
  end

  // read data held through the ack phase
  always_ff @(posedge clk) begin
    if (csr_go) csr_rdt <= rd_val;
  end

endmodule

/* verilog/lsu_csr_pkg.sv */
////////////////////////////////////////////////////////////////////////////
// load/store register map
// addresses, widths and control bit positions of the register block
////////////////////////////////////////////////////////////////////////////

package lsu_csr_pkg;

  // register port widths
  localparam int unsigned csr_aw = 2;
  localparam int unsigned csr_dw = 32;

  // control register
  localparam logic [csr_aw-1:0] csr_ctrl = 2'd0;
  // trap misaligned accesses instead of wrapping
  localparam int unsigned csr_ctrl_trap = 0;

  // misaligned request counter, write clears
  localparam logic [csr_aw-1:0] csr_mal_cnt = 2'd1;

  // total request counter, write clears
  localparam logic [csr_aw-1:0] csr_acc_cnt = 2'd2;

endpackage

/* verilog/lsu_slice.sv */
////////////////////////////////////////////////////////////////////////////
// valid/ready register slice
// two-entry skid buffer, registered ready, one transfer per cycle
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module lsu_slice #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     rst,
  // upstream
  input  logic     in_vld,
  input  payload_t in_data,
  output logic     in_rdy,
  // downstream
  output logic     out_vld,
  output payload_t out_data,
  input  logic     out_rdy
);

  // skid entry
  logic     skd_vld;
  payload_t skd_data;
  // upstream transfer
  logic     in_acc;
  // output register can take new data
  logic     out_free;

  assign in_acc   = in_vld & in_rdy;
  assign out_free = out_rdy | ~out_vld;

  // control
  always_ff @(posedge clk) begin
    if (rst) begin
      out_vld <= 1'b0;
      skd_vld <= 1'b0;
      in_rdy  <= 1'b0;
    end else begin
      if (out_free) begin
        // skid drains first, else pass the input
        out_vld <= skd_vld | in_acc;
        skd_vld <= 1'b0;
        in_rdy  <= 1'b1;
      end else if (in_acc) begin
        // output stalled, park in skid
        skd_vld <= 1'b1;
        in_rdy  <= 1'b0;
      end
    end
  end

  // payload
  always_ff @(posedge clk) begin
    if (out_free) begin
      out_data <= skd_vld ? skd_data : in_data;
    end else if (in_acc) begin
      skd_data <= in_data;
    end
  end

endmodule

/* verilog/lsu_sram.sv */
////////////////////////////////////////////////////////////////////////////
// single-cycle word memory
// byte enable writes, one request per cycle, one response register
// held until taken
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module lsu_sram (
  input  logic                           clk,
  input  logic                           rst,
  // request
  input  logic                           mem_vld,
  input  logic                           mem_wen,
  input  logic [lsu_bus_pkg::mem_aw-1:0] mem_adr,
  input  logic [lsu_bus_pkg::bus_bw-1:0] mem_ben,
  input  logic [lsu_bus_pkg::bus_dw-1:0] mem_wdt,
  output logic                           mem_rdy,
  // response
  output logic                           mem_rsp_vld,
  output logic [lsu_bus_pkg::bus_dw-1:0] mem_rdt,
  input  logic                           mem_rsp_rdy
);

  import lsu_bus_pkg::*;

  // storage
  logic [bus_dw-1:0] mem [mem_words];

  logic mem_acc;

  // stall only while a response sits untaken
  assign mem_rdy = ~mem_rsp_vld | mem_rsp_rdy;
  assign mem_acc = mem_vld & mem_rdy;

  // byte lane writes
  always_ff @(posedge clk) begin
    if (mem_acc && mem_wen) begin
      for (int i = 0; i < bus_bw; i++) begin
        if (mem_ben[i]) mem[mem_adr][8*i +: 8] <= mem_wdt[8*i +: 8];
      end
    end
  end

////////////////////////////////////////////////////////////////////////////
// response register
////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      mem_rsp_vld <= 1'b0;
    end else if (mem_acc) begin
      mem_rsp_vld <= 1'b1;
    end else if (mem_rsp_rdy) begin
      mem_rsp_vld <= 1'b0;
    end
  end

  // whole word on read, zero on write
  always_ff @(posedge clk) begin
    if (mem_acc) begin
      mem_rdt <= mem_wen ? '0 : mem[mem_adr];
    end
  end

endmodule

/* verilog/lsu_top.sv */
////////////////////////////////////////////////////////////////////////////
// load/store path top level
// request slice, aligner, word memory and response slice with the
// register block steering misaligned handling
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module lsu_top (
  input  logic                           clk,
  input  logic                           rst,
  // request
  input  logic                           req_vld,
  input  logic                           req_wen,
  input  logic                           req_ndn,
  input  logic [lsu_bus_pkg::siz_w-1:0]  req_siz,
  input  logic [lsu_bus_pkg::bus_aw-1:0] req_adr,
  input  logic [lsu_bus_pkg::bus_dw-1:0] req_wdt,
  output logic                           req_rdy,
  output logic                           mal,
  // response
  output logic                           rsp_vld,
  output logic [lsu_bus_pkg::bus_dw-1:0] rsp_rdt,
  output logic                           rsp_sts,
  input  logic                           rsp_rdy,
  // register port
  input  logic                           csr_req,
  input  logic                           csr_wen,
  input  logic [lsu_csr_pkg::csr_aw-1:0] csr_adr,
  input  logic [lsu_csr_pkg::csr_dw-1:0] csr_wdt,
  output logic                           csr_ack,
  output logic [lsu_csr_pkg::csr_dw-1:0] csr_rdt
);

  import lsu_bus_pkg::*;

  lsu_req_t          req_in;
  lsu_req_t          req_s_data;
  logic              req_s_vld;
  logic              req_s_rdy;
  lsu_rsp_t          rsp_a_data;
  lsu_rsp_t          rsp_out;
  logic              rsp_a_vld;
  logic              rsp_a_rdy;
  logic              mem_vld;
  logic              mem_wen;
  logic [mem_aw-1:0] mem_adr;
  logic [bus_bw-1:0] mem_ben;
  logic [bus_dw-1:0] mem_wdt;
  logic              mem_rdy;
  logic              mem_rsp_vld;
  logic [bus_dw-1:0] mem_rdt;
  logic              mem_rsp_rdy;
  logic              trap;
  logic              acc_evt;
  logic              mal_evt;

  // same decode as the aligner, seen on the core side
  assign mal = lsu_mal(req_siz, req_adr[1:0]);

  assign req_in  = '{wen: req_wen, ndn: req_ndn, siz: req_siz, adr: req_adr, wdt: req_wdt};
  assign rsp_rdt = rsp_out.rdt;
  assign rsp_sts = rsp_out.sts;

  lsu_slice #(.payload_t(lsu_req_t)) u_req_slice (
    .clk, .rst,
    .in_vld (req_vld),   .in_data (req_in),     .in_rdy (req_rdy),
    .out_vld(req_s_vld), .out_data(req_s_data), .out_rdy(req_s_rdy)
  );

  lsu_align u_align (
    .clk, .rst,
    .req_vld(req_s_vld), .req_data(req_s_data), .req_rdy(req_s_rdy),
    .mem_vld, .mem_wen, .mem_adr, .mem_ben, .mem_wdt, .mem_rdy,
    .mem_rsp_vld, .mem_rdt, .mem_rsp_rdy,
    .rsp_vld(rsp_a_vld), .rsp_data(rsp_a_data), .rsp_rdy(rsp_a_rdy),
    .trap, .acc_evt, .mal_evt
  );

  lsu_csr u_csr (
    .clk, .rst,
    .csr_req, .csr_wen, .csr_adr, .csr_wdt, .csr_ack, .csr_rdt,
    .acc_evt, .mal_evt, .trap
  );

  lsu_sram u_sram (
    .clk, .rst,
    .mem_vld, .mem_wen, .mem_adr, .mem_ben, .mem_wdt, .mem_rdy,
    .mem_rsp_vld, .mem_rdt, .mem_rsp_rdy
  );

  lsu_slice #(.payload_t(lsu_rsp_t)) u_rsp_slice (
    .clk, .rst,
    .in_vld (rsp_a_vld), .in_data (rsp_a_data), .in_rdy (rsp_a_rdy),
    .out_vld(rsp_vld),   .out_data(rsp_out),    .out_rdy(rsp_rdy)
  );

endmodule
